/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = i2s_tx_tb
FILELIST = src.f
LOG      = sim.log
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* i2s_axil_regs.sv */
// AXI4-Lite slave with control and status registers that pushes written samples to the FIFO
`timescale 1ns/1ps

module i2s_axil_regs
    import i2s_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    arst_n,
    // Write address and data
    input  logic [AXI_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXI_DATA_W-1:0]   wdata,
    input  logic [AXI_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    // Write response
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // Read address and data
    input  logic [AXI_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [AXI_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Core side
    output i2s_ctrl_t               ctrl,
    input  i2s_status_t             status,
    output logic                    push,
    output stereo_sample_t          push_data,
    output logic                    clear_overflow,
    output logic                    clear_underrun
);

    logic                  wr_ready;              // Shared awready/wready strobe
    logic                  wr_fire;               // Address and data taken this cycle
    logic                  rd_fire;               // Read address taken this cycle
    logic [AXI_DATA_W-1:0] rd_word;               // Decoded read value

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign bresp   = 2'b00;                       // Always OKAY
    assign rresp   = 2'b00;

    assign wr_fire = wr_ready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    // Read mux, SAMPLE is write-only and reads as zero like unmapped space
    always_comb begin
        case (araddr)
            REG_CTRL:   rd_word = {16'b0, ctrl.clk_div, 6'b0, ctrl.bclk_invert, ctrl.enable};
            REG_STATUS: rd_word = AXI_DATA_W'(status);
            default:    rd_word = '0;
        endcase
    end

    // Write channel and control register
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ready       <= 1'b0;
            bvalid         <= 1'b0;
            ctrl           <= '0;                 // Transmitter starts disabled
            push           <= 1'b0;
            clear_overflow <= 1'b0;
            clear_underrun <= 1'b0;
        end else begin
            // Single cycle ready once both channels wait and no response is pending
            wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;                   // Response accepted
            end
            push           <= wr_fire && (awaddr == REG_SAMPLE);
            clear_overflow <= wr_fire && (awaddr == REG_STATUS) && wstrb[0] && wdata[6];
            clear_underrun <= wr_fire && (awaddr == REG_STATUS) && wstrb[0] && wdata[7];
            if (wr_fire && (awaddr == REG_CTRL)) begin
                if (wstrb[0]) begin
                    ctrl.enable      <= wdata[0];
                    ctrl.bclk_invert <= wdata[1];
                end
                if (wstrb[1]) begin
                    ctrl.clk_div <= wdata[15:8];
                end
            end
        end
    end

    // Read channel handshake
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;    // One read outstanding
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_in) begin
        if (wr_fire) begin
            push_data <= stereo_sample_t'(wdata); // Qualified later by push
        end
        if (rd_fire) begin
            rdata <= rd_word;                     // Held until rready
        end
    end

endmodule

/* i2s_clock_gen.sv */
// Bit clock divider producing a 50/50 serial clock and a pulse at each bit period start
`timescale 1ns/1ps

module i2s_clock_gen (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       enable,
    input  logic [7:0] clk_div,
    output logic       bclk,
    output logic       bit_pulse
);

    logic [7:0] div_cnt;                          // Cycles left in this half period

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt   <= '0;
            bclk      <= 1'b0;
            bit_pulse <= 1'b0;
        end else if (!enable) begin
            // Idle, first toggle comes right after enable
            div_cnt   <= '0;
            bclk      <= 1'b0;
            bit_pulse <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt   <= clk_div;                 // Half period is clk_div+1 cycles
            bclk      <= ~bclk;
            bit_pulse <= ~bclk;                   // Only on the rising toggle
        end else begin
            div_cnt   <= div_cnt - 1;
            bit_pulse <= 1'b0;
        end
    end

endmodule

/* i2s_pkg.sv */
// I2S transmitter package with audio widths, register map and the shared structs
package i2s_pkg;

    // Audio framing
    localparam int AUDIO_BITS = 16;               // Sample width per channel
    localparam int FRAME_BITS = 64;               // Bit periods per stereo frame, half per slot

    // Sample buffer
    localparam int FIFO_DEPTH   = 8;              // Stereo samples held
    localparam int FIFO_LEVEL_W = 4;              // Counts 0 to FIFO_DEPTH inclusive

    // AXI4-Lite bus
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    // Register byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_SAMPLE = 4'h8;

    // One stereo frame, same layout as the SAMPLE register
    typedef struct packed {
        logic [AUDIO_BITS-1:0] right;             // Upper half
        logic [AUDIO_BITS-1:0] left;              // Lower half
    } stereo_sample_t;

    // Control fields held by the register block
    typedef struct packed {
        logic [7:0] clk_div;                      // Bit clock half period is clk_div+1 cycles
        logic       bclk_invert;                  // Output bit clock falls mid period when set
        logic       enable;                       // Runs clock generator and transmitter
    } i2s_ctrl_t;

    // Status fields, packed in STATUS register bit order
    typedef struct packed {
        logic                    underrun;        // Bit 7, sticky
        logic                    overflow;        // Bit 6, sticky
        logic                    fifo_empty;      // Bit 5
        logic                    fifo_full;       // Bit 4
        logic [FIFO_LEVEL_W-1:0] fifo_level;      // Bits 3..0
    } i2s_status_t;

endpackage

/* i2s_sample_fifo.sv */
// Stereo sample FIFO with level, full and empty flags and sticky overflow and underrun
`timescale 1ns/1ps

module i2s_sample_fifo
    import i2s_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  logic                    push,
    input  stereo_sample_t          push_data,
    input  logic                    pop,
    output stereo_sample_t          pop_data,
    input  logic                    clear_overflow,
    input  logic                    clear_underrun,
    output logic [FIFO_LEVEL_W-1:0] level,
    output logic                    full,
    output logic                    empty,
    output logic                    overflow,
    output logic                    underrun
);

    stereo_sample_t                 mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr, rd_ptr;   // Wrap naturally, depth is a power of two
    logic [FIFO_LEVEL_W-1:0]        count;
    logic                           do_push, do_pop;

    assign full     = (count == FIFO_LEVEL_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign level    = count;
    assign do_push  = push && !full;              // Pushes into a full buffer are dropped
    assign do_pop   = pop && !empty;
    assign pop_data = empty ? '0 : mem[rd_ptr];   // Silence when nothing is buffered

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
            underrun <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1;
            if (do_pop)  rd_ptr <= rd_ptr + 1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1;
                2'b01:   count <= count - 1;
                default: count <= count;          // Both or neither
            endcase
            // A new error wins over a clear in the same cycle
            if (push && full) overflow <= 1'b1;
            else if (clear_overflow) overflow <= 1'b0;
            if (pop && empty) underrun <= 1'b1;
            else if (clear_underrun) underrun <= 1'b0;
        end
    end

endmodule

/* i2s_transmitter.sv */
// I2S frame serializer driving word clock, data and the phase aligned bit clock
`timescale 1ns/1ps

module i2s_transmitter
    import i2s_pkg::*;
(
    input  logic           clk_in,
    input  logic           arst_n,
    input  logic           enable,
    input  logic           bclk_invert,
    input  logic           bclk,
    input  logic           bit_pulse,
    output logic           pop,
    input  stereo_sample_t pop_data,
    output logic           i2s_bclk,
    output logic           i2s_wclk,
    output logic           i2s_data
);

    logic [$clog2(FRAME_BITS)-1:0] bit_cnt;       // Bit period within the frame
    logic [AUDIO_BITS-1:0]         shift_q;       // Serial data, MSB goes out first
    logic [AUDIO_BITS-1:0]         right_q;       // Right sample waiting for its slot
    logic                          frame_active;  // Set after the first frame is fetched
    logic                          frame_start;

    // Counter wraps from 63 to 0 here
    assign frame_start = enable && bit_pulse && (bit_cnt == '1);
    assign pop         = frame_start;             // FIFO head taken this same cycle
    assign i2s_wclk    = frame_active && bit_cnt[$clog2(FRAME_BITS)-1];  // High in right slot
    assign i2s_data    = shift_q[AUDIO_BITS-1];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt      <= '1;
            shift_q      <= '0;
            frame_active <= 1'b0;
            i2s_bclk     <= 1'b0;
        end else begin
            // One cycle behind raw bclk, default polarity rises mid bit period
            i2s_bclk <= frame_active && (bclk ^ ~bclk_invert);
            if (!enable) begin
                bit_cnt      <= '1;               // Next bit_pulse opens a frame
                shift_q      <= '0;
                frame_active <= 1'b0;
            end else if (bit_pulse) begin
                bit_cnt <= bit_cnt + 1;
                if (frame_start) begin
                    shift_q      <= pop_data.left;
                    frame_active <= 1'b1;
                end else if (bit_cnt == $clog2(FRAME_BITS)'(FRAME_BITS/2 - 1)) begin
                    shift_q <= right_q;           // Start of right slot
                end else begin
                    shift_q <= shift_q << 1;      // Zero fill after the sample bits
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (frame_start) begin
            right_q <= pop_data.right;            // Both channels captured together
        end
    end

endmodule

/* i2s_tx_tb.sv */
// Testbench for the AXI4-Lite I2S transmitter with a FIFO model and an I2S deserializer
`timescale 1ns/1ps

module i2s_tx_tb
    import i2s_pkg::*;
;

    logic                    clk_in, arst_n;
    logic [AXI_ADDR_W-1:0]   awaddr, araddr;
    logic [AXI_DATA_W-1:0]   wdata, rdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    awvalid, awready, wvalid, wready, bvalid, bready;
    logic                    arvalid, arready, rvalid, rready;
    logic [1:0]              bresp, rresp;
    logic                    i2s_bclk, i2s_wclk, i2s_data;

    // Frame length in clk_in cycles for a given divider
    localparam int F1 = 2 * FRAME_BITS * 2;
    localparam int F7 = 2 * FRAME_BITS * 8;
    // 36 frames at divider 1 and 9 frames at divider 7, with 50 percent headroom
    localparam real BUDGET_NS = 1.5 * (36.0 * F1 + 9.0 * F7) * 100.0;

    int             errors, checks, frames_rx, idx, base, test_err;
    logic           fresh, last_wclk, cur_invert;
    logic [31:0]    slot, rd, exp_frame;
    logic [15:0]    got_left;
    logic           model_ovf, model_unr;
    stereo_sample_t model_q [$];                      // Samples the FIFO should hold
    realtime        last_data_t, last_fall_t, last_rise_t, t0;

    tb_clock clock_i (.clk_in, .arst_n);

    i2s_tx_top dut_i (.*);

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk_in);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk_in); while (!awready);       // Pre-edge value seen here
        check("wready", 32'(wready), 32'h1);          // Raised together with awready
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat ($urandom_range(0, 3)) @(posedge clk_in);
        bready <= 1'b1;
        do @(posedge clk_in); while (!bvalid);
        check("bresp", 32'(bresp), 32'h0);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk_in);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk_in); while (!arready);
        arvalid <= 1'b0;
        repeat ($urandom_range(0, 3)) @(posedge clk_in);
        rready <= 1'b1;
        do @(posedge clk_in); while (!rvalid);
        data = rdata;
        check("rresp", 32'(rresp), 32'h0);
        rready <= 1'b0;
    endtask

    // CTRL write, the monitor restarts on disable
    task automatic set_ctrl(input logic [31:0] v);
        axi_write(REG_CTRL, v);
        cur_invert = v[1];
        if (!v[0]) begin
            fresh = 1'b1;
            idx   = 0;
        end
    endtask

    task automatic push_sample(input logic [31:0] s);
        axi_write(REG_SAMPLE, s);
        if (model_q.size() < FIFO_DEPTH) model_q.push_back(stereo_sample_t'(s));
        else model_ovf = 1'b1;                        // Dropped by a full FIFO
    endtask

    task automatic check_status();
        logic [31:0] exp;
        exp = {24'b0, model_unr, model_ovf, model_q.size() == 0,
               model_q.size() == FIFO_DEPTH, 4'(model_q.size())};
        axi_read(REG_STATUS, rd);
        check("status", rd, exp);
    endtask

    task automatic wait_frames(input int n);
        while (frames_rx < n) @(posedge clk_in);
    endtask

    task automatic report(input string name);
        test_err = errors - test_err;
        if (test_err == 0) $display("Test %s: passed", name);
        else $display("Test %s: failed with %0d errors", name, test_err);
        test_err = errors;
    endtask

    always @(i2s_data) last_data_t = $realtime;

    // Data holds from each rising bit clock up to the next fall
    always @(negedge i2s_bclk) begin
        if (!fresh && !cur_invert && last_data_t >= last_rise_t && last_data_t < $realtime) begin
            errors++;
            $display("Serial data changed while the bit clock was high");
        end
        last_fall_t = $realtime;
    end

    // Deserializer, samples data at the rising bit clock
    always @(posedge i2s_bclk) begin
        if (!fresh && !cur_invert && last_data_t > last_fall_t) begin
            errors++;
            $display("Serial data changed while the bit clock was low");
        end
        last_rise_t = $realtime;
        if (fresh || i2s_wclk != last_wclk) begin
            if (!fresh) check("slot_bits", idx, 32);
            idx       = 0;
            last_wclk = i2s_wclk;
            fresh     = 1'b0;
            if (!i2s_wclk) begin
                if (model_q.size() > 0) exp_frame = model_q.pop_front();
                else begin
                    exp_frame = '0;                   // Empty FIFO sends silence
                    model_unr = 1'b1;
                end
            end
        end
        slot = {slot[30:0], i2s_data};
        idx++;
        if (idx == 32) begin
            check("slot_pad", 32'(slot[15:0]), 32'h0);
            if (!i2s_wclk) got_left = slot[31:16];
            else begin
                check("left", 32'(got_left), 32'(exp_frame[15:0]));
                check("right", 32'(slot[31:16]), 32'(exp_frame[31:16]));
                frames_rx++;
            end
        end
    end

    initial begin
        #(BUDGET_NS);
        $display("Timeout: the run took longer than its time budget");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] v;
        int          sent, div;
        void'($urandom(32'h7f8cd7c5));
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        {errors, checks, frames_rx, idx, test_err} = '0;
        {fresh, last_wclk, cur_invert, model_ovf, model_unr} = 5'b10000;
        last_data_t = 0;
        last_fall_t = 0;
        last_rise_t = 0;
        @(posedge arst_n);
        repeat (2) @(posedge clk_in);

        // Random CTRL values with the transmitter kept off
        repeat (4) begin
            v = $urandom & 32'h0000_ff02;
            set_ctrl(v);
            axi_read(REG_CTRL, rd);
            check("ctrl", rd, v);
        end
        axi_read(REG_SAMPLE, rd);
        check("sample_read", rd, 32'h0);
        axi_read(4'hc, rd);
        check("unmapped_read", rd, 32'h0);
        set_ctrl(32'h0);
        report("1 register access");

        // 20 samples in bursts of 4, FIFO kept between 1 and 8 entries
        for (sent = 0; sent < 4; sent++) push_sample($urandom);
        base = frames_rx;
        set_ctrl(32'h0000_0101);
        while (sent < 20) begin
            while (model_q.size() > 4) @(posedge clk_in);
            repeat (4) begin
                push_sample($urandom);
                sent++;
            end
        end
        while (model_q.size() > 0) @(posedge clk_in);
        wait_frames(base + 21);
        set_ctrl(32'h0);
        report("2 serialization");

        // Bit clock period and word clock length
        repeat (3) begin
            div = $urandom_range(0, 7);
            set_ctrl({16'b0, 8'(div), 8'h01});
            axi_read(REG_CTRL, rd);
            check("ctrl", rd, {16'b0, 8'(div), 8'h01});   // Enable bit read back while running
            @(posedge i2s_bclk);
            t0 = $realtime;
            repeat (4) @(posedge i2s_bclk);
            check("bclk_period", int'(($realtime - t0) / 400.0), 2 * (div + 1));
            base = frames_rx;
            wait_frames(base + 2);
            set_ctrl(32'h0);
        end
        report("3 clock rate");

        // Overfill with the transmitter idle
        repeat (FIFO_DEPTH + 2) begin
            push_sample($urandom);
            check_status();
        end
        report("4 fifo status");

        // Clear the underrun left by earlier tests, drain past empty, then clear both flags
        axi_write(REG_STATUS, 32'h80);
        model_unr = 1'b0;
        check_status();
        base = frames_rx;
        set_ctrl(32'h0000_0101);
        while (model_q.size() > 0) @(posedge clk_in);
        wait_frames(base + FIFO_DEPTH + 2);
        set_ctrl(32'h0);
        check_status();
        axi_write(REG_STATUS, 32'h80);
        model_unr = 1'b0;
        check_status();
        axi_write(REG_STATUS, 32'h40);
        model_ovf = 1'b0;
        check_status();
        report("5 underrun");

        $display("Checks: %0d, errors: %0d, frames: %0d", checks, errors, frames_rx);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* i2s_tx_top.sv */
// Top of the AXI4-Lite I2S transmitter joining registers, FIFO, clock divider and serializer
`timescale 1ns/1ps

module i2s_tx_top
    import i2s_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  logic [AXI_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXI_DATA_W-1:0]   wdata,
    input  logic [AXI_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [AXI_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [AXI_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic                    i2s_bclk,
    output logic                    i2s_wclk,
    output logic                    i2s_data
);

    i2s_ctrl_t               ctrl;
    i2s_status_t             status;
    stereo_sample_t          push_data, pop_data;
    logic                    push, pop, clear_overflow, clear_underrun;
    logic [FIFO_LEVEL_W-1:0] level;
    logic                    full, empty, overflow, underrun;
    logic                    bclk, bit_pulse;

    // STATUS word built from the FIFO flags
    assign status = '{underrun: underrun, overflow: overflow, fifo_empty: empty,
                      fifo_full: full, fifo_level: level};

    i2s_axil_regs regs_i (
        .clk_in, .arst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ctrl, .status, .push, .push_data, .clear_overflow, .clear_underrun
    );

    i2s_sample_fifo fifo_i (
        .clk_in, .arst_n, .push, .push_data, .pop, .pop_data,
        .clear_overflow, .clear_underrun, .level, .full, .empty, .overflow, .underrun
    );

    i2s_clock_gen clock_gen_i (
        .clk_in, .arst_n, .enable(ctrl.enable), .clk_div(ctrl.clk_div), .bclk, .bit_pulse
    );

    i2s_transmitter transmitter_i (
        .clk_in, .arst_n, .enable(ctrl.enable), .bclk_invert(ctrl.bclk_invert),
        .bclk, .bit_pulse, .pop, .pop_data, .i2s_bclk, .i2s_wclk, .i2s_data
    );

endmodule

/* src.f */
i2s_pkg.sv
i2s_axil_regs.sv
i2s_sample_fifo.sv
i2s_clock_gen.sv
i2s_transmitter.sv
i2s_tx_top.sv
tb_clock.sv
i2s_tx_tb.sv

/* tb_clock.sv */
// Testbench clock and reset source with a 100 ns clock and a 5 cycle reset
`timescale 1ns/1ps

module tb_clock (
    output logic clk_in,
    output logic arst_n
);

    initial begin
        clk_in = 1'b0;
        arst_n = 1'b0;                                // Held low through the first 5 edges
        repeat (5) @(posedge clk_in);
        arst_n <= 1'b1;
    end

    always #50 clk_in = ~clk_in;                      // 100 ns period

endmodule
